//--- common/joy_pkg.sv
/*
 * Shared constants and types for the joystick cursor demo.
 * Holds the 640x480 VGA timing, the cursor reset point, the default
 * movement divider and the direction type used by the position logic.
 * Modules pull these in with a wildcard import in their header.
 */

`default_nettype none

package joy_pkg;

	// horizontal timing, in pixel clocks
	localparam int unsigned h_display = 640;
	localparam int unsigned h_front   = 16;
	localparam int unsigned h_sync    = 96;
	localparam int unsigned h_back    = 48;
	localparam int unsigned h_total   = h_display + h_front + h_sync + h_back;

	// vertical timing, in lines
	localparam int unsigned v_display = 480;
	localparam int unsigned v_front   = 10;
	localparam int unsigned v_sync    = 2;
	localparam int unsigned v_back    = 33;
	localparam int unsigned v_total   = v_display + v_front + v_sync + v_back;

	// every pixel coordinate uses this width
	localparam int unsigned coord_w = 10;

	// cursor starts in the middle of the screen
	localparam int unsigned x_reset = 320;
	localparam int unsigned y_reset = 240;

	// 25 MHz / 250000 gives a 100 Hz movement rate
	localparam int unsigned move_div_default = 250000;

	// direction acted on in one movement tick
	typedef enum logic [2:0] {
		dir_none  = 3'd0,
		dir_left  = 3'd1,
		dir_right = 3'd2,
		dir_up    = 3'd3,
		dir_down  = 3'd4
	} move_dir_t;

endpackage

`default_nettype wire

//--- video/vga_scan_timing.sv
/*
 * Raster scan generator for a 640x480 screen at the 25 MHz pixel clock.
 * Produces the pixel coordinates, the active-low sync pulses, the
 * display window flag and a one-cycle strobe at the start of vsync.
 */

`timescale 1ns/1ps
`default_nettype none

module vga_scan_timing
	import joy_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               reset,
	output logic [coord_w-1:0]      hpos,
	output logic [coord_w-1:0]      vpos,
	output logic                    display_on,
	output logic                    hsync,
	output logic                    vsync,
	output logic                    frame_start
);

	localparam logic [coord_w-1:0] h_last = coord_w'(h_total - 1);
	localparam logic [coord_w-1:0] v_last = coord_w'(v_total - 1);

	// sync windows, first and one-past-last position
	localparam logic [coord_w-1:0] hs_begin = coord_w'(h_display + h_front);
	localparam logic [coord_w-1:0] hs_end   = coord_w'(h_display + h_front + h_sync);
	localparam logic [coord_w-1:0] vs_begin = coord_w'(v_display + v_front);
	localparam logic [coord_w-1:0] vs_end   = coord_w'(v_display + v_front + v_sync);

	localparam logic [coord_w-1:0] h_vis = coord_w'(h_display);
	localparam logic [coord_w-1:0] v_vis = coord_w'(v_display);

	logic h_wrap;
	logic v_wrap;

	assign h_wrap = (hpos == h_last);
	assign v_wrap = (vpos == v_last);

	// pixel counter
	always_ff @(posedge clk) begin
		if (reset) begin
			hpos <= '0;
		end else if (h_wrap) begin
			hpos <= '0;
		end else begin
			hpos <= hpos + 1'b1;
		end
	end

	// line counter, steps once per full line
	always_ff @(posedge clk) begin
		if (reset) begin
			vpos <= '0;
		end else if (h_wrap) begin
			if (v_wrap) begin
				vpos <= '0;
			end else begin
				vpos <= vpos + 1'b1;
			end
		end
	end

	assign display_on = (hpos < h_vis) && (vpos < v_vis);

	// both syncs are active low
	assign hsync = !((hpos >= hs_begin) && (hpos < hs_end));
	assign vsync = !((vpos >= vs_begin) && (vpos < vs_end));

	// vpos only changes as hpos wraps to zero, so this is
	// the first cycle of the vsync pulse
	assign frame_start = (hpos == '0) && (vpos == vs_begin);

	a_hpos_range : assert property (
		@(posedge clk) disable iff (reset)
		hpos < coord_w'(h_total)
	) else $error("hpos left the line range");

endmodule

`default_nettype wire

//--- video/cursor_render.sv
/*
 * Colours the screen from a per-frame copy of the cursor point.
 * Green marks columns at or right of the cursor, blue rows at or below it.
 * Sync and colour are registered together so they leave on the same cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module cursor_render
	import joy_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               frame_start,
	input  wire logic               display_on,
	input  wire logic               hsync_in,
	input  wire logic               vsync_in,
	input  wire logic [coord_w-1:0] hpos,
	input  wire logic [coord_w-1:0] vpos,
	input  wire logic [coord_w-1:0] joy_x,
	input  wire logic [coord_w-1:0] joy_y,
	output logic                    hsync,
	output logic                    vsync,
	output logic [2:0]              rgb
);

	// cursor point held steady for a whole frame
	logic [coord_w-1:0] frame_x;
	logic [coord_w-1:0] frame_y;

	logic green;
	logic blue;

	always_ff @(posedge clk) begin
		if (reset) begin
			frame_x <= coord_w'(x_reset);
			frame_y <= coord_w'(y_reset);
		end else if (frame_start) begin
			frame_x <= joy_x;
			frame_y <= joy_y;
		end
	end

	assign green = display_on && (hpos >= frame_x);
	assign blue  = display_on && (vpos >= frame_y);

	// one stage of alignment for sync and colour
	always_ff @(posedge clk) begin
		if (reset) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			rgb   <= 3'b000;
		end else begin
			hsync <= hsync_in;
			vsync <= vsync_in;
			// red is always off
			rgb   <= {1'b0, green, blue};
		end
	end

endmodule

`default_nettype wire

//--- joystick/move_tick.sv
/*
 * Free-running divider giving a one-cycle movement enable.
 * The enable fires every DIVIDE clocks and stands in for a slow clock.
 */

`timescale 1ns/1ps
`default_nettype none

module move_tick
	import joy_pkg::*;
#(
	parameter int unsigned DIVIDE = move_div_default
) (
	input  wire logic clk,
	input  wire logic reset,
	output logic      tick
);

	localparam int unsigned cnt_w = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(DIVIDE - 1);

	logic [cnt_w-1:0] count;

	assign tick = (count == cnt_last);

	// wraps on the tick cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (tick) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	a_tick_single : assert property (
		@(posedge clk) disable iff (reset)
		tick |=> !tick
	) else $error("movement tick held for more than one cycle");

endmodule

`default_nettype wire

//--- joystick/cursor_position.sv
/*
 * Joystick cursor point driven by four direction buttons.
 * Buttons are synchronized, one direction is chosen per tick with
 * priority left, right, up, down, and the point is kept on screen.
 */

`timescale 1ns/1ps
`default_nettype none

module cursor_position
	import joy_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               tick,
	input  wire logic               left,
	input  wire logic               right,
	input  wire logic               up,
	input  wire logic               down,
	output logic [coord_w-1:0]      joy_x,
	output logic [coord_w-1:0]      joy_y
);

	localparam logic [coord_w-1:0] x_max = coord_w'(h_display - 1);
	localparam logic [coord_w-1:0] y_max = coord_w'(v_display - 1);

	// bit order is left, right, up, down
	logic [3:0] btn_meta;
	logic [3:0] btn_sync;
	move_dir_t  dir;

	always_ff @(posedge clk) begin
		if (reset) begin
			btn_meta <= '0;
			btn_sync <= '0;
		end else begin
			btn_meta <= {left, right, up, down};
			btn_sync <= btn_meta;
		end
	end

	// a blocked direction falls through to the next one
	always_comb begin
		dir = dir_none;
		if (tick) begin
			if (btn_sync[3] && joy_x != '0) begin
				dir = dir_left;
			end else if (btn_sync[2] && joy_x < x_max) begin
				dir = dir_right;
			end else if (btn_sync[1] && joy_y != '0) begin
				dir = dir_up;
			end else if (btn_sync[0] && joy_y < y_max) begin
				dir = dir_down;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			joy_x <= coord_w'(x_reset);
			joy_y <= coord_w'(y_reset);
		end else begin
			case (dir)
				dir_left:  joy_x <= joy_x - 1'b1;
				dir_right: joy_x <= joy_x + 1'b1;
				dir_up:    joy_y <= joy_y - 1'b1;
				dir_down:  joy_y <= joy_y + 1'b1;
				default: ;
			endcase
		end
	end

	a_x_on_screen : assert property (
		@(posedge clk) disable iff (reset)
		joy_x < coord_w'(h_display)
	) else $error("cursor x off screen");

	a_y_on_screen : assert property (
		@(posedge clk) disable iff (reset)
		joy_y < coord_w'(v_display)
	) else $error("cursor y off screen");

endmodule

`default_nettype wire

//--- design/joy_demo_top.sv
/*
 * Joystick cursor demo on a 640x480 VGA output, all on the pixel clock.
 * MOVE_DIV sets how many pixel clocks pass between cursor steps.
 */

`timescale 1ns/1ps
`default_nettype none

module joy_demo_top
	import joy_pkg::*;
#(
	parameter int unsigned MOVE_DIV = move_div_default
) (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic left,
	input  wire logic right,
	input  wire logic up,
	input  wire logic down,
	output logic      hsync,
	output logic      vsync,
	output logic [2:0] rgb
);

	logic [coord_w-1:0] hpos;
	logic [coord_w-1:0] vpos;
	logic               display_on;
	logic               frame_start;
	// syncs before the output alignment stage
	logic               hsync_raw;
	logic               vsync_raw;
	logic               tick;
	logic [coord_w-1:0] joy_x;
	logic [coord_w-1:0] joy_y;

	vga_scan_timing vga_scan_timing_inst (
		.clk         (clk),
		.reset       (reset),
		.hpos        (hpos),
		.vpos        (vpos),
		.display_on  (display_on),
		.hsync       (hsync_raw),
		.vsync       (vsync_raw),
		.frame_start (frame_start)
	);

	move_tick #(
		.DIVIDE (MOVE_DIV)
	) move_tick_inst (
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	cursor_position cursor_position_inst (
		.clk   (clk),
		.reset (reset),
		.tick  (tick),
		.left  (left),
		.right (right),
		.up    (up),
		.down  (down),
		.joy_x (joy_x),
		.joy_y (joy_y)
	);

	cursor_render cursor_render_inst (
		.clk         (clk),
		.reset       (reset),
		.frame_start (frame_start),
		.display_on  (display_on),
		.hsync_in    (hsync_raw),
		.vsync_in    (vsync_raw),
		.hpos        (hpos),
		.vpos        (vpos),
		.joy_x       (joy_x),
		.joy_y       (joy_y),
		.hsync       (hsync),
		.vsync       (vsync),
		.rgb         (rgb)
	);

endmodule

`default_nettype wire

//--- test/tb_joy_demo.sv
/*
 * Testbench for the joystick cursor demo.
 * Steps through a table of button presses and follows the cursor, the frame
 * snapshot and the raster in a reference model. Every output sample is
 * checked, and the colour boundaries of each frame are measured from rgb.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_joy_demo
	import joy_pkg::*;
();

	localparam int unsigned clk_period = 4;
	localparam int unsigned move_div   = 8;
	localparam int unsigned n_rows     = 10;
	localparam longint unsigned frame_len = h_total * v_total;

	// buttons in the order left, right, up, down
	typedef struct packed {
		logic [3:0]         btn;
		logic               extra;
		logic [15:0]        ticks;
		logic [coord_w-1:0] exp_x;
		logic [coord_w-1:0] exp_y;
	} row_t;

	logic       clk;
	logic       reset;
	logic       left;
	logic       right;
	logic       up;
	logic       down;
	logic       hsync;
	logic       vsync;
	logic [2:0] rgb;

	row_t        rows [n_rows];
	logic        table_ready;
	int unsigned seed_draw;

	// reference model of cursor, synchronizer and frame point
	longint unsigned edge_cnt;
	int unsigned     m_x;
	int unsigned     m_y;
	int unsigned     fr_x;
	int unsigned     fr_y;
	logic [3:0]      m_sync1;
	logic [3:0]      m_sync2;
	int unsigned     snap_count;

	// boundaries measured from the colour output
	logic [coord_w-1:0] cur_x;
	logic [coord_w-1:0] cur_y;
	logic [coord_w-1:0] meas_x;
	logic [coord_w-1:0] meas_y;
	int unsigned        meas_count;

	joy_demo_top #(
		.MOVE_DIV (move_div)
	) joy_demo_top_inst (
		.clk   (clk),
		.reset (reset),
		.left  (left),
		.right (right),
		.up    (up),
		.down  (down),
		.hsync (hsync),
		.vsync (vsync),
		.rgb   (rgb)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	task automatic report_error(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic check_sync(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			report_error($sformatf("%s is %b, expected %b", name, got, exp));
		end
	endtask

	task automatic check_rgb(input logic [2:0] got, input logic [2:0] exp,
			input int unsigned h, input int unsigned v);
		if (got !== exp) begin
			report_error($sformatf("rgb at column %0d row %0d is %b, expected %b",
				h, v, got, exp));
		end
	endtask

	task automatic check_coord(input logic [coord_w-1:0] got_x,
			input logic [coord_w-1:0] got_y,
			input logic [coord_w-1:0] exp_x,
			input logic [coord_w-1:0] exp_y);
		if (got_x !== exp_x || got_y !== exp_y) begin
			report_error($sformatf("colour boundary at (%0d,%0d), expected (%0d,%0d)",
				got_x, got_y, exp_x, exp_y));
		end
	endtask

	// one tick of movement where a blocked direction falls through
	task automatic step_cursor(input logic [3:0] btn);
		if (btn[3] && m_x != 0) begin
			m_x = m_x - 1;
		end else if (btn[2] && m_x < h_display - 1) begin
			m_x = m_x + 1;
		end else if (btn[1] && m_y != 0) begin
			m_y = m_y - 1;
		end else if (btn[0] && m_y < v_display - 1) begin
			m_y = m_y + 1;
		end
	endtask

	task automatic load_table();
		// buttons, extra random button, ticks, expected x, expected y
		rows[0] = {4'b0000, 1'b0, 16'd0, 10'd320, 10'd240};
		rows[1] = {4'b0100, 1'b0, 16'd5, 10'd325, 10'd240};
		rows[2] = {4'b0001, 1'b0, 16'd7, 10'd325, 10'd247};
		rows[3] = {4'b1000, 1'b0, 16'd12, 10'd313, 10'd247};
		rows[4] = {4'b0010, 1'b0, 16'd20, 10'd313, 10'd227};
		// left wins over up or down
		rows[5] = {4'b1000, 1'b1, 16'd6, 10'd307, 10'd227};
		// up wins over down
		rows[6] = {4'b0011, 1'b0, 16'd4, 10'd307, 10'd223};
		// runs into the left, top and right edges
		rows[7] = {4'b1000, 1'b0, 16'd400, 10'd0, 10'd223};
		rows[8] = {4'b0010, 1'b0, 16'd300, 10'd0, 10'd0};
		rows[9] = {4'b0100, 1'b0, 16'd700, 10'd639, 10'd0};
	endtask

	task automatic apply_row(input row_t row);
		logic [3:0]  btn;
		int unsigned snaps;
		int unsigned meas;
		btn = row.btn;
		if (row.extra) begin
			btn = btn | (($urandom % 2) ? 4'b0010 : 4'b0001);
		end
		@(negedge clk);
		{left, right, up, down} = btn;
		repeat (row.ticks * move_div) @(negedge clk);
		{left, right, up, down} = 4'b0000;
		// let the synchronizer drain before waiting for a fresh snapshot
		repeat (4) @(negedge clk);
		snaps = snap_count;
		while (snap_count == snaps) begin
			@(negedge clk);
		end
		meas = meas_count;
		while (meas_count == meas) begin
			@(posedge clk);
		end
		check_coord(meas_x, meas_y, row.exp_x, row.exp_y);
	endtask

	always @(posedge clk) begin
		if (reset) begin
			edge_cnt   = 0;
			m_x        = x_reset;
			m_y        = y_reset;
			fr_x       = x_reset;
			fr_y       = y_reset;
			m_sync1    = 4'b0000;
			m_sync2    = 4'b0000;
			snap_count = 0;
		end else begin
			edge_cnt = edge_cnt + 1;
			// first cycle of vsync is taken before this edge's move
			if ((edge_cnt - 1) % frame_len == (v_display + v_front) * h_total) begin
				fr_x       = m_x;
				fr_y       = m_y;
				snap_count = snap_count + 1;
			end
			if (edge_cnt % move_div == 0) begin
				step_cursor(m_sync2);
			end
			m_sync2 = m_sync1;
			m_sync1 = {left, right, up, down};
		end
	end

	// outputs after edge k show the scan position k-1
	always @(negedge clk) begin : monitor
		longint unsigned pos;
		int unsigned     h;
		int unsigned     v;
		logic            exp_hs;
		logic            exp_vs;
		logic [2:0]      exp_rgb;
		// no edge out of reset has happened yet
		if (edge_cnt == 0) begin
			check_sync(hsync, 1'b1, "hsync in reset");
			check_sync(vsync, 1'b1, "vsync in reset");
			check_rgb(rgb, 3'b000, 0, 0);
			meas_count = 0;
		end else begin
			pos = (edge_cnt - 1) % frame_len;
			h = pos % h_total;
			v = pos / h_total;
			exp_hs = !(h >= h_display + h_front && h < h_display + h_front + h_sync);
			exp_vs = !(v >= v_display + v_front && v < v_display + v_front + v_sync);
			exp_rgb = 3'b000;
			if (h < h_display && v < v_display) begin
				exp_rgb = {1'b0, h >= fr_x, v >= fr_y};
			end
			check_sync(hsync, exp_hs, "hsync");
			check_sync(vsync, exp_vs, "vsync");
			check_rgb(rgb, exp_rgb, h, v);
			if (pos == 0) begin
				cur_x = coord_w'(h_display);
				cur_y = coord_w'(v_display);
			end
			// first green column on the top line and first blue row in column zero
			if (v == 0 && rgb[1] && cur_x == coord_w'(h_display)) begin
				cur_x = coord_w'(h);
			end
			if (h == 0 && rgb[0] && cur_y == coord_w'(v_display)) begin
				cur_y = coord_w'(v);
			end
			if (h == h_display - 1 && v == v_display - 1) begin
				meas_x     = cur_x;
				meas_y     = cur_y;
				meas_count = meas_count + 1;
			end
		end
	end

	initial begin : watchdog
		longint unsigned tick_sum;
		longint unsigned limit;
		wait (table_ready === 1'b1);
		tick_sum = 0;
		for (int i = 0; i < n_rows; i++) begin
			tick_sum = tick_sum + rows[i].ticks;
		end
		// each row waits at most two frames for its snapshot and measurement
		limit = tick_sum * move_div + (2 * n_rows + 3) * frame_len;
		limit = limit + limit / 8;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, the test did not finish", limit);
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		reset       = 1'b1;
		left        = 1'b0;
		right       = 1'b0;
		up          = 1'b0;
		down        = 1'b0;
		table_ready = 1'b0;
		seed_draw   = $urandom(88);
		load_table();
		table_ready = 1'b1;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < n_rows; i++) begin
			apply_row(rows[i]);
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
common/joy_pkg.sv
video/vga_scan_timing.sv
video/cursor_render.sv
joystick/move_tick.sv
joystick/cursor_position.sv
design/joy_demo_top.sv
test/tb_joy_demo.sv

//--- Bender.yml
package:
  name: joy_demo

sources:
  # shared package first
  - common/joy_pkg.sv

  # video path
  - video/vga_scan_timing.sv
  - video/cursor_render.sv

  # joystick path
  - joystick/move_tick.sv
  - joystick/cursor_position.sv

  # top level
  - design/joy_demo_top.sv

  # testbench
  - target: test
    files:
      - test/tb_joy_demo.sv
